//--- sbusMem.f
logic/sbusPkg.sv
logic/memPkg.sv
logic/sbusRequester.sv
logic/corePhase.sv
logic/readCollector.sv
logic/sbusMemTop.sv
bench/sbusMemChecker.sv
bench/sbusMemTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the storage bus memory testbench with Verilator and runs it
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module sbusMemTb -f sbusMem.f -o sbusMemSim
./obj_dir/sbusMemSim | tee sim.log

if grep -q "test failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
echo "simulation clean"

//--- bench/sbusMemTb.sv
////////////////////////////////////////////////////////////
// Drives loads and commands on the falling edge and keeps a
// shadow copy of core to build the expected quadword words.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module sbusMemTb
  import sbusPkg::*, memPkg::*;
();

  localparam int nLoads    = memWords + 2;  // Fill plus two bad parity words
  localparam int nCmds     = 112;           // Commands over all tests
  localparam int maxCycles = 2 * (2 * nLoads + 8 * nCmds + 4);

  logic        SBUS, arstN, cmdStart, busy, cmdDone;
  busAddr      cmdAddr, loadAddr;
  rqMask       cmdRq;
  logic        loadEn, loadPar, rdValid, rdParErr;
  busWord      loadData, rdData;
  logic [15:0] wordCount;

  busWord      tbMem [memWords];  // Shadow of core contents
  logic        tbPar [memWords];  // Stored parity as loaded
  logic [31:0] lcgState;
  int          expCount;          // Words owed since reset
  int          cycleCount;

  sbusMemTop     i_dut (.*);
  sbusMemChecker i_checker (.*);

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic busAddr randAddr();
    return busAddr'(nextRand() >> 10);  // Upper LCG bits are the better ones
  endfunction

  function automatic busWord randWord();
    logic [31:0] hi;
    hi = nextRand();
    return {hi[31:28], nextRand()};
  endfunction

  // Expected words of one transfer in bus order, returns the word count
  function automatic int expectQuad(input busAddr a, input rqMask m,
      input busWord memCopy [memWords], input logic parCopy [memWords],
      output busWord words [quadWords], output logic errs [quadWords]);
    int n;
    int idx;
    n = 0;
    for (int k = 0; k < quadWords; k++) begin
      words[k] = '0;
      errs[k]  = 1'b0;
    end
    for (int k = 0; k < quadWords; k++) begin
      if (m[k]) begin
        idx = ((int'(a) & ~3) | ((int'(a) + k) & 3)) % memWords;  // Wrap in quad
        words[n] = memCopy[idx];
        errs[n]  = (^memCopy[idx]) != parCopy[idx];
        n++;
      end
    end
    return n;
  endfunction

  task automatic loadWord(input busAddr a, input busWord d, input logic p);
    @(negedge SBUS);
    loadEn   = 1'b1;
    loadAddr = a;
    loadData = d;
    loadPar  = p;
    tbMem[int'(a) % memWords] = d;  // Upper bits alias
    tbPar[int'(a) % memWords] = p;
    @(negedge SBUS);
    loadEn = 1'b0;
  endtask

  // Optionally repeats cmdStart once while busy, which must be dropped
  task automatic issueCommand(input busAddr a, input rqMask m, input logic pokeWhileBusy);
    busWord words [quadWords];
    logic   errs  [quadWords];
    int     n;
    int     hi;
    int     waited;
    n = expectQuad(a, m, tbMem, tbPar, words, errs);
    for (int k = 0; k < n; k++) begin
      i_checker.expectWord(words[k], errs[k]);
    end
    expCount += n;
    hi = 0;
    for (int k = 0; k < quadWords; k++) begin
      if (m[k]) hi = k;              // Highest requested position
    end
    @(negedge SBUS);
    cmdStart = 1'b1;
    cmdAddr  = a;
    cmdRq    = m;
    @(negedge SBUS);
    waited = 1;
    if (pokeWhileBusy) begin
      cmdAddr = a ^ 22'h2;
      cmdRq   = 4'b1111;
      @(negedge SBUS);
      waited++;
    end
    cmdStart = 1'b0;
    while (!cmdDone) begin
      @(negedge SBUS);
      waited++;
    end
    i_checker.checkLatency(waited, 3 + hi);  // Start, load, then one cycle per position
    @(negedge SBUS);                         // Last word reaches the checker
  endtask

  task automatic dropZeroMask(input busAddr a);
    @(negedge SBUS);
    cmdStart = 1'b1;
    cmdAddr  = a;
    cmdRq    = '0;
    @(negedge SBUS);
    cmdStart = 1'b0;
    repeat (6) begin
      @(negedge SBUS);
      if (busy) i_checker.noteFailure("busy rose for a command with an empty mask");
    end
  endtask

  initial begin
    SBUS = 1'b0;
    forever #10 SBUS = ~SBUS;
  end

  initial begin
    cycleCount = 0;
    while (cycleCount < maxCycles) begin
      @(posedge SBUS);
      cycleCount++;
    end
    $display("timeout: run did not finish within %0d cycles", maxCycles);
    $display("test failed");
    $finish;
  end

  initial begin
    busAddr a;
    busWord d;
    rqMask  m;
    lcgState = 32'ha210_3a67;
    expCount = 0;
    arstN    = 1'b0;
    cmdStart = 1'b0;
    cmdAddr  = '0;
    cmdRq    = '0;
    loadEn   = 1'b0;
    loadAddr = '0;
    loadData = '0;
    loadPar  = 1'b0;
    repeat (4) @(negedge SBUS);
    arstN = 1'b1;
    @(negedge SBUS);
    i_checker.checkIdle();
    i_checker.finishTest("reset state", expCount);

    // Random fill with good parity, random upper bits exercise aliasing
    for (int i = 0; i < memWords; i++) begin
      d = randWord();
      a = randAddr();
      loadWord({a[21:10], 10'(i)}, d, ^d);
    end

    a = randAddr();
    for (int off = 0; off < quadWords; off++) begin
      issueCommand({a[21:2], 2'(off)}, 4'b1111, 1'b0);
    end
    i_checker.finishTest("full mask wrap", expCount);

    issueCommand(randAddr(), 4'b1010, 1'b0);
    issueCommand(randAddr(), 4'b0001, 1'b0);
    issueCommand(randAddr(), 4'b0110, 1'b0);
    issueCommand(randAddr(), 4'b1000, 1'b0);
    i_checker.finishTest("sparse masks", expCount);

    a = randAddr();
    d = randWord();
    loadWord({a[21:2], 2'd1}, d, ~^d);  // Planted bad parity
    d = randWord();
    loadWord({a[21:2], 2'd3}, d, ~^d);
    issueCommand({a[21:2], 2'd0}, 4'b1111, 1'b0);
    issueCommand({a[21:2], 2'd2}, 4'b1111, 1'b0);
    i_checker.finishTest("bad parity", expCount);

    issueCommand(randAddr(), 4'b0101, 1'b1);
    dropZeroMask(randAddr());
    i_checker.finishTest("dropped commands", expCount);

    repeat (100) begin
      a = randAddr();
      m = rqMask'(nextRand() >> 28);
      if (m == '0) m = 4'b0100;
      issueCommand(a, m, 1'b0);
    end
    i_checker.finishTest("random reads", expCount);

    $display("%0d tests, %0d failed, %0d errors", i_checker.testsRun,
             i_checker.testsFailed, i_checker.errCount);
    if (i_checker.errCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- bench/sbusMemChecker.sv
////////////////////////////////////////////////////////////
// Compares result words in order against a queue of expected
// words. Samples on the falling edge, where outputs are stable.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module sbusMemChecker
  import sbusPkg::*;
(
  input logic        SBUS,
  input logic        arstN,
  input logic        busy,
  input logic        rdValid,
  input busWord      rdData,
  input logic        rdParErr,
  input logic [15:0] wordCount
);

  busWord expData [$];    // Words still owed, in bus order
  logic   expErr  [$];    // Parity flag owed with each word
  int     errCount    = 0;
  int     testErrs    = 0; // Errors inside the running test
  int     testsRun    = 0;
  int     testsFailed = 0;

  task automatic noteMismatch(input string sig, input logic [35:0] got,
                              input logic [35:0] exp);
    $display("mismatch at %0d ns: %s got %h expected %h", $time, sig, got, exp);
    errCount++;
    testErrs++;
  endtask

  task automatic noteFailure(input string what);
    $display("error at %0d ns: %s", $time, what);
    errCount++;
    testErrs++;
  endtask

  task automatic expectWord(input busWord d, input logic e);
    expData.push_back(d);
    expErr.push_back(e);
  endtask

  // Cycles from the command drive to the cmdDone pulse
  task automatic checkLatency(input int got, input int exp);
    if (got != exp) begin
      noteMismatch("cmdDone latency", 36'(got), 36'(exp));
    end
  endtask

  task automatic checkIdle();
    if (rdValid !== 1'b0) noteMismatch("rdValid", 36'(rdValid), 36'd0);
    if (busy !== 1'b0) noteMismatch("busy", 36'(busy), 36'd0);
    if (rdParErr !== 1'b0) noteMismatch("rdParErr", 36'(rdParErr), 36'd0);
    if (wordCount !== 16'd0) noteMismatch("wordCount", 36'(wordCount), 36'd0);
  endtask

  // Closes a test, anything still queued never came back
  task automatic finishTest(input string name, input int expCount);
    if (expData.size() != 0) begin
      noteFailure($sformatf("%0d expected words never arrived", expData.size()));
      expData.delete();
      expErr.delete();
    end
    if (wordCount !== 16'(expCount)) begin
      noteMismatch("wordCount", 36'(wordCount), 36'(16'(expCount)));
    end
    testsRun++;
    if (testErrs == 0) begin
      $display("%-18s ok", name);
    end else begin
      testsFailed++;
      $display("%-18s %0d errors", name, testErrs);
    end
    testErrs = 0;
  endtask

  always @(negedge SBUS) begin
    if (arstN && rdValid) begin
      if (expData.size() == 0) begin
        noteFailure($sformatf("word %h arrived with no read outstanding", rdData));
      end else begin
        if (rdData !== expData[0]) noteMismatch("rdData", rdData, expData[0]);
        if (rdParErr !== expErr[0]) begin
          noteMismatch("rdParErr", 36'(rdParErr), 36'(expErr[0]));
        end
        void'(expData.pop_front());
        void'(expErr.pop_front());
      end
    end
  end

endmodule

//--- logic/sbusMemTop.sv
////////////////////////////////////////////////////////////
// Requester, one core phase and collector on one bus.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module sbusMemTop
  import sbusPkg::*;
(
  input  logic        SBUS,
  input  logic        arstN,
  // Command port
  input  logic        cmdStart,
  input  busAddr      cmdAddr,
  input  rqMask       cmdRq,
  output logic        busy,
  output logic        cmdDone,
  // Load port
  input  logic        loadEn,
  input  busAddr      loadAddr,
  input  busWord      loadData,
  input  logic        loadPar,
  // Result port
  output logic        rdValid,
  output busWord      rdData,
  output logic        rdParErr,
  output logic [15:0] wordCount
);

  logic   start;      // Bus start level
  busAddr adr;
  rqMask  rq;
  logic   ackn;       // Per word acknowledge
  logic   dataValid;
  busWord busD;
  logic   dataPar;

  sbusRequester i_requester (
    .SBUS    (SBUS),
    .arstN   (arstN),
    .cmdStart(cmdStart),
    .cmdAddr (cmdAddr),
    .cmdRq   (cmdRq),
    .ackn    (ackn),
    .start   (start),
    .adr     (adr),
    .rq      (rq),
    .busy    (busy),
    .cmdDone (cmdDone)
  );

  corePhase i_phase (
    .SBUS     (SBUS),
    .arstN    (arstN),
    .start    (start),
    .adr      (adr),
    .rq       (rq),
    .loadEn   (loadEn),
    .loadAddr (loadAddr),
    .loadData (loadData),
    .loadPar  (loadPar),
    .ackn     (ackn),
    .dataValid(dataValid),
    .busD     (busD),
    .dataPar  (dataPar)
  );

  readCollector i_collector (
    .SBUS     (SBUS),
    .arstN    (arstN),
    .dataValid(dataValid),
    .busD     (busD),
    .dataPar  (dataPar),
    .rdValid  (rdValid),
    .rdData   (rdData),
    .rdParErr (rdParErr),
    .wordCount(wordCount)
  );

endmodule

//--- logic/readCollector.sv
////////////////////////////////////////////////////////////
// Takes every valid bus word, no back-pressure possible.
// Word count is 16 bits and wraps.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module readCollector
  import sbusPkg::*;
(
  input  logic        SBUS,
  input  logic        arstN,
  input  logic        dataValid,
  input  busWord      busD,
  input  logic        dataPar,
  output logic        rdValid,
  output busWord      rdData,
  output logic        rdParErr,
  output logic [15:0] wordCount
);

  logic parBad;  // Recomputed parity disagrees with bus

  // Good word when XOR of data matches stored parity
  assign parBad = (^busD) != dataPar;

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      rdValid   <= 1'b0;
      rdParErr  <= 1'b0;
      wordCount <= '0;
    end else begin
      rdValid  <= dataValid;            // One stage behind the bus
      rdParErr <= dataValid && parBad;  // Flag only real words
      if (dataValid) begin
        wordCount <= wordCount + 16'd1;
      end
    end
  end

  // Data register, only meaningful with rdValid
  always_ff @(posedge SBUS) begin
    if (dataValid) begin
      rdData <= busD;
    end
  end

  // Memory drives zero data and parity between words
  busIdlesZero: assert property (@(posedge SBUS) disable iff (!arstN)
    !dataValid |-> (busD == '0) && !dataPar);

endmodule

//--- logic/corePhase.sv
////////////////////////////////////////////////////////////
// One non-interleaved phase of core, read quadwords only.
// Load port must stay quiet while a transfer is running.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module corePhase
  import sbusPkg::*, memPkg::*;
(
  input  logic   SBUS,
  input  logic   arstN,
  input  logic   start,
  input  busAddr adr,
  input  rqMask  rq,
  input  logic   loadEn,
  input  busAddr loadAddr,
  input  busWord loadData,
  input  logic   loadPar,
  output logic   ackn,
  output logic   dataValid,
  output busWord busD,
  output logic   dataPar
);

  busWord  mem    [memWords];  // Core array
  logic    parMem [memWords];  // Parity bit kept as loaded
  memState state;
  memIdx   baseIdx;            // Quadword base, low bits unused
  wordOff  curOff;             // Current word, wraps mod 4
  rqMask   remMask;            // Positions still to run, bit 0 is current
  memIdx   rdIdx;
  memIdx   loadIdx;
  logic    takeReq;            // Start seen while idle

  assign takeReq = (state == phIdle) && start;

  // Upper address bits beyond the array are dropped, memory aliases
  assign loadIdx = memIdx'(loadAddr);
  assign rdIdx   = {baseIdx[memIdxBits-1:$bits(wordOff)], curOff};

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      state   <= phIdle;
      curOff  <= '0;
      remMask <= '0;
    end else begin
      unique case (state)
        phIdle: begin
          if (start) begin
            state   <= phRun;
            curOff  <= wordOff'(adr);     // First word is the addressed one
            remMask <= rq;
          end
        end
        phRun: begin
          curOff  <= curOff + 1'b1;
          remMask <= remMask >> 1;
          // Done after the highest requested position
          if ((remMask >> 1) == '0) begin
            state <= phIdle;
          end
        end
        default: state <= phIdle;
      endcase
    end
  end

  always_ff @(posedge SBUS) begin
    if (takeReq) begin
      baseIdx <= memIdx'(adr);
    end
  end

  // Preload path, parity stored exactly as given
  always_ff @(posedge SBUS) begin
    if (loadEn) begin
      mem[loadIdx]    <= loadData;
      parMem[loadIdx] <= loadPar;
    end
  end

  // Skipped positions burn a cycle with no ack
  assign ackn      = (state == phRun) && remMask[0];
  assign dataValid = (state == phRun) && remMask[0];

  assign busD    = dataValid ? mem[rdIdx] : '0;     // Bus idles at zero
  assign dataPar = dataValid ? parMem[rdIdx] : 1'b0;

  // Preloading during a transfer would race the read path
  noLoadInRun: assert property (@(posedge SBUS) disable iff (!arstN)
    loadEn |-> state == phIdle);

  // A run always has a requested position left
  runHasWork: assert property (@(posedge SBUS) disable iff (!arstN)
    state == phRun |-> remMask != '0);

endmodule

//--- logic/sbusRequester.sv
////////////////////////////////////////////////////////////
// Issues one read quadword at a time, no overlap of commands.
// Commands while busy or with an empty mask are dropped.
////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module sbusRequester
  import sbusPkg::*;
(
  input  logic   SBUS,
  input  logic   arstN,
  input  logic   cmdStart,
  input  busAddr cmdAddr,
  input  rqMask  cmdRq,
  input  logic   ackn,
  output logic   start,
  output busAddr adr,
  output rqMask  rq,
  output logic   busy,
  output logic   cmdDone
);

  logic [2:0] ackNeed;  // Acks owed for this command
  logic [2:0] ackSeen;  // Acks received so far
  logic       accept;   // Command taken this cycle
  logic       lastAck;  // Final ack of the command

  // Number of set request bits, one ack comes back per word
  function automatic logic [2:0] popCount(input rqMask m);
    logic [2:0] n;
    n = '0;
    for (int k = 0; k < quadWords; k++) begin
      n = n + 3'(m[k]);
    end
    return n;
  endfunction

  assign accept  = cmdStart && !busy && (cmdRq != '0);
  assign lastAck = ackn && ((ackSeen + 3'd1) == ackNeed);

  always_ff @(posedge SBUS or negedge arstN) begin
    if (!arstN) begin
      start   <= 1'b0;
      busy    <= 1'b0;
      cmdDone <= 1'b0;
      ackSeen <= '0;
      ackNeed <= '0;
    end else begin
      cmdDone <= 1'b0;                    // Single cycle pulse
      if (accept) begin
        start   <= 1'b1;                  // Raise start at acceptance
        busy    <= 1'b1;
        ackSeen <= '0;
        ackNeed <= popCount(cmdRq);
      end else if (busy && ackn) begin
        start   <= 1'b0;                  // Memory has latched us by now
        ackSeen <= ackSeen + 3'd1;
        if (lastAck) begin
          busy    <= 1'b0;
          cmdDone <= 1'b1;
        end
      end
    end
  end

  // Address and mask stay put until the next accepted command
  always_ff @(posedge SBUS) begin
    if (accept) begin
      adr <= cmdAddr;
      rq  <= cmdRq;
    end
  end

  // Start falls no later than busy
  startNeedsBusy: assert property (@(posedge SBUS) disable iff (!arstN)
    start |-> busy);

  // Memory must not acknowledge a transfer nobody asked for
  acknNeedsBusy: assert property (@(posedge SBUS) disable iff (!arstN)
    ackn |-> busy);

endmodule

//--- logic/memPkg.sv
////////////////////////////////////////////////////////////
// Core memory geometry. Address bits above memIdxBits are
// ignored, so the array aliases through the full bus space.
////////////////////////////////////////////////////////////
package memPkg;

  localparam int memIdxBits = 10;               // Address bits decoded
  localparam int memWords   = 1 << memIdxBits;  // 1024 stored words

  // Index into the core array
  typedef logic [memIdxBits-1:0] memIdx;

  // Phase FSM, idle or returning words of a quadword
  typedef enum logic {
    phIdle,
    phRun
  } memState;

endpackage

//--- logic/sbusPkg.sv
////////////////////////////////////////////////////////////
// Storage bus types shared by requester, memory and collector.
// Word bits are numbered 35..0 here, not in KL10 0..35 order.
////////////////////////////////////////////////////////////
package sbusPkg;

  // Bus widths
  localparam int busWordBits = 36;  // One KL10 data word
  localparam int busAddrBits = 22;  // Physical word address
  localparam int quadWords   = 4;   // Words moved per quadword cycle

  // One data word as it travels on the bus
  typedef logic [busWordBits-1:0] busWord;

  // Word address, low two bits pick the word inside the quadword
  typedef logic [busAddrBits-1:0] busAddr;

  // Request mask, bit k asks for sequence position k
  typedef logic [quadWords-1:0] rqMask;

  // Word offset inside the quadword, wraps mod 4
  typedef logic [$clog2(quadWords)-1:0] wordOff;

endpackage
